/* logic/raster_config.svh */
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// Signed Q16.16 fixed-point format.
`define FIXED_WIDTH 32
`define FIXED_FRAC 16

// Entries per stream FIFO.
`define FIFO_DEPTH 4

// Width of the running triangle id, which wraps.
`define TRI_ID_WIDTH 8

// Raw fixed value of 2.0.
`define SMALL_AREA_LIMIT 32'sh0002_0000

`endif

/* logic/raster_pkg.sv */
`default_nettype none

`include "raster_config.svh"

package raster_pkg;

    typedef logic signed [`FIXED_WIDTH-1:0] fixed;  // Signed Q16.16.

    typedef struct packed {
        fixed x;
        fixed y;
    } position_t;

    typedef struct packed {
        position_t position;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic [`TRI_ID_WIDTH-1:0] id;
    } triangle_meta_t;

    typedef struct packed {
        triangle_t      triangle;
        triangle_meta_t meta;
    } tagged_triangle_t;

    typedef struct packed {
        fixed top;     // Smallest y.
        fixed bottom;  // Largest y.
        fixed left;
        fixed right;
    } bounding_box_t;

    typedef struct packed {
        triangle_t      triangle;
        fixed           area_inv;
        logic           small_area;
        bounding_box_t  bounding_box;
        triangle_meta_t meta;
    } attributed_triangle_t;

endpackage

`default_nettype wire

/* logic/triangle_assembler.sv */
`default_nettype none

`include "raster_config.svh"

module triangle_assembler (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    vertex_valid,
    output logic                         vertex_ready,
    input  wire raster_pkg::vertex_t     vertex,
    output logic                         tri_valid,
    input  wire logic                    tri_ready,
    output raster_pkg::tagged_triangle_t tri_data
);
    logic [1:0]               slot;    // Slot of the next vertex.
    logic [`TRI_ID_WIDTH-1:0] tri_id;
    logic                     vertex_take;

    assign vertex_ready = !tri_valid;  // Stall while a triangle waits.
    assign vertex_take  = vertex_valid && vertex_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot      <= '0;
            tri_valid <= 1'b0;
            tri_id    <= '0;
        end else begin
            if (vertex_take) begin
                slot <= (slot == 2'd2) ? 2'd0 : slot + 2'd1;
                if (slot == 2'd2) begin
                    tri_valid <= 1'b1;
                end
            end
            if (tri_valid && tri_ready) begin
                tri_valid <= 1'b0;
                tri_id    <= tri_id + 1'b1;  // Id advances after the handoff.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vertex_take) begin
            case (slot)
                2'd0: tri_data.triangle.v0 <= vertex;
                2'd1: tri_data.triangle.v1 <= vertex;
                default: begin
                    tri_data.triangle.v2 <= vertex;
                    tri_data.meta.id     <= tri_id;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        tri_valid && !tri_ready |=> tri_valid && $stable(tri_data))
        else $error("Triangle changed while waiting for tri_ready.");

endmodule

`default_nettype wire

/* logic/stream_fifo.sv */
`default_nettype none

`include "raster_config.svh"

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);
    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    payload_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? PTR_WIDTH'(0) : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != COUNT_WIDTH'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) count <= COUNT_WIDTH'(DEPTH))
        else $error("FIFO count above depth.");

    // Equal pointers on a pop mean a full FIFO.
    assert property (@(posedge clk) disable iff (!rstn)
        pop |-> (rd_ptr != wr_ptr) || (count == COUNT_WIDTH'(DEPTH)))
        else $error("Pop from an empty FIFO.");

endmodule

`default_nettype wire

/* logic/fixed_reciprocal.sv */
`default_nettype none

`include "raster_config.svh"

module fixed_reciprocal (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             start,
    input  wire raster_pkg::fixed divisor,
    output logic                  done,
    output raster_pkg::fixed      result
);
    import raster_pkg::*;

    localparam int W          = `FIXED_WIDTH;
    localparam int STEP_WIDTH = $clog2(W + 1);

    logic                  busy;
    logic [STEP_WIDTH-1:0] steps;     // Quotient bits still to come.
    logic                  neg;
    logic [W-1:0]          mag;
    logic [W-1:0]          rem;
    logic [W-1:0]          quo;
    logic [W-1:0]          step_mag;
    logic [W-1:0]          step_rem;
    logic [W-1:0]          step_quo;
    logic [W:0]            trial;
    logic                  q_bit;
    logic [W:0]            q_full;
    logic                  last_step;
    fixed                  result_next;

    // The single set bit of the 2^W dividend enters on the start cycle.
    assign step_mag  = start ? (divisor[W-1] ? -divisor : divisor) : mag;
    assign step_rem  = start ? '0 : rem;
    assign step_quo  = start ? '0 : quo;
    assign trial     = {step_rem, start};
    assign q_bit     = (trial >= {1'b0, step_mag});
    assign q_full    = {step_quo, q_bit};
    assign last_step = busy && (steps == STEP_WIDTH'(1));

    always_comb begin
        if (neg) begin
            if (q_full[W] || (q_full[W-1] && |q_full[W-2:0])) begin
                result_next = {1'b1, {(W-1){1'b0}}};  // Most negative.
            end else begin
                result_next = -fixed'(q_full[W-1:0]);
            end
        end else if (q_full[W] || q_full[W-1]) begin
            result_next = {1'b0, {(W-1){1'b1}}};  // Largest positive for zero divisor too.
        end else begin
            result_next = fixed'(q_full[W-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy  <= 1'b0;
            steps <= '0;
            done  <= 1'b0;
        end else begin
            done <= last_step;
            if (start) begin
                busy  <= 1'b1;
                steps <= STEP_WIDTH'(W);
            end else if (busy) begin
                steps <= steps - 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            rem <= q_bit ? W'(trial - {1'b0, step_mag}) : trial[W-1:0];
            quo <= {step_quo[W-2:0], q_bit};
        end
        if (start) begin
            mag <= step_mag;
            neg <= divisor[W-1];
        end
        if (last_step) begin
            result <= result_next;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) start |-> !busy)
        else $error("Divider started while busy.");

endmodule

`default_nettype wire

/* logic/triangle_setup.sv */
`default_nettype none

`include "raster_config.svh"

module triangle_setup (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        tri_valid,
    output logic                             tri_ready,
    input  wire raster_pkg::tagged_triangle_t tri_data,
    output logic                             attr_valid,
    input  wire logic                        attr_ready,
    output raster_pkg::attributed_triangle_t attr_data
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        AREA,    // Cross terms settle.
        LATCH,   // Area registered, divider starts.
        INVERT,
        DONE     // Result waits for attr_ready.
    } setup_state_t;

    setup_state_t   state;
    setup_state_t   state_next;
    triangle_t      triangle;
    triangle_meta_t meta;
    fixed           area_c;
    fixed           area_r;
    fixed           area_inv;
    logic           area_inv_done;
    logic           divider_start;
    logic           small_area;
    bounding_box_t  bounding_box;

    // Q16.16 product keeps the middle bits of the full product.
    function automatic fixed fmul(input fixed a, input fixed b);
        logic signed [2*`FIXED_WIDTH-1:0] p;
        p = a * b;
        return p[`FIXED_FRAC +: `FIXED_WIDTH];
    endfunction

    function automatic fixed tri_area(input position_t p0, input position_t p1,
                                      input position_t p2);
        return fmul(p1.y - p2.y, p0.x) + fmul(p2.y - p0.y, p1.x) + fmul(p0.y - p1.y, p2.x);
    endfunction

    function automatic fixed min3(input fixed a, input fixed b, input fixed c);
        fixed m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic fixed max3(input fixed a, input fixed b, input fixed c);
        fixed m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign tri_ready     = (state == IDLE);
    assign attr_valid    = (state == DONE);
    assign divider_start = (state == LATCH);

    assign area_c = tri_area(triangle.v0.position, triangle.v1.position, triangle.v2.position);
    assign small_area = (area_r < `SMALL_AREA_LIMIT);  // Negative areas count too.

    assign bounding_box.top    = min3(triangle.v0.position.y, triangle.v1.position.y,
                                      triangle.v2.position.y);
    assign bounding_box.bottom = max3(triangle.v0.position.y, triangle.v1.position.y,
                                      triangle.v2.position.y);
    assign bounding_box.left   = min3(triangle.v0.position.x, triangle.v1.position.x,
                                      triangle.v2.position.x);
    assign bounding_box.right  = max3(triangle.v0.position.x, triangle.v1.position.x,
                                      triangle.v2.position.x);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (tri_valid) state_next = AREA;
            AREA:    state_next = LATCH;
            LATCH:   state_next = INVERT;
            INVERT:  if (area_inv_done) state_next = DONE;
            DONE:    if (attr_ready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (tri_valid && tri_ready) begin
            triangle <= tri_data.triangle;
            meta     <= tri_data.meta;
        end
        if (state == AREA) begin
            area_r <= area_c;
        end
        if (area_inv_done) begin
            attr_data.triangle     <= triangle;
            attr_data.area_inv     <= area_inv;
            attr_data.small_area   <= small_area;
            attr_data.bounding_box <= bounding_box;
            attr_data.meta         <= meta;
        end
    end

    fixed_reciprocal divider_i (
        .clk     (clk),
        .rstn    (rstn),
        .start   (divider_start),
        .divisor (area_r),
        .done    (area_inv_done),
        .result  (area_inv)
    );

    assert property (@(posedge clk) disable iff (!rstn)
        attr_valid && !attr_ready |=> attr_valid && $stable(attr_data))
        else $error("Setup result changed while waiting for attr_ready.");

endmodule

`default_nettype wire

/* logic/raster_setup_top.sv */
`default_nettype none

module raster_setup_top (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        vertex_valid,
    output logic                             vertex_ready,
    input  wire raster_pkg::vertex_t         vertex,
    output logic                             out_valid,
    input  wire logic                        out_ready,
    output raster_pkg::attributed_triangle_t out
);
    import raster_pkg::*;

    logic                 asm_valid;
    logic                 asm_ready;
    tagged_triangle_t     asm_data;
    logic                 setup_in_valid;
    logic                 setup_in_ready;
    tagged_triangle_t     setup_in_data;
    logic                 attr_valid;
    logic                 attr_ready;
    attributed_triangle_t attr_data;

    triangle_assembler assembler_i (
        .clk          (clk),
        .rstn         (rstn),
        .vertex_valid (vertex_valid),
        .vertex_ready (vertex_ready),
        .vertex       (vertex),
        .tri_valid    (asm_valid),
        .tri_ready    (asm_ready),
        .tri_data     (asm_data)
    );

    stream_fifo #(.payload_t(tagged_triangle_t)) in_fifo_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (asm_valid),
        .in_ready  (asm_ready),
        .in_data   (asm_data),
        .out_valid (setup_in_valid),
        .out_ready (setup_in_ready),
        .out_data  (setup_in_data)
    );

    triangle_setup setup_i (
        .clk        (clk),
        .rstn       (rstn),
        .tri_valid  (setup_in_valid),
        .tri_ready  (setup_in_ready),
        .tri_data   (setup_in_data),
        .attr_valid (attr_valid),
        .attr_ready (attr_ready),
        .attr_data  (attr_data)
    );

    stream_fifo #(.payload_t(attributed_triangle_t)) out_fifo_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (attr_valid),
        .in_ready  (attr_ready),
        .in_data   (attr_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out)
    );

endmodule

`default_nettype wire

/* testbench/tb_raster_setup.sv */
`default_nettype none

`include "raster_config.svh"

module tb_raster_setup;
    import raster_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 51745;
    localparam int DRAIN_CYCLES = 50;

    logic                 clk;
    logic                 rstn;
    logic                 vertex_valid;
    logic                 vertex_ready;
    vertex_t              vertex;
    logic                 out_valid;
    logic                 out_ready;
    attributed_triangle_t out;

    vertex_t              vertex_q[$];
    attributed_triangle_t expect_q[$];
    int                   tri_count;
    int                   checked;
    int                   mismatches;
    int                   failures;
    logic                 loaded;
    logic                 draining;

    raster_setup_top raster_setup_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .vertex_valid (vertex_valid),
        .vertex_ready (vertex_ready),
        .vertex       (vertex),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out          (out)
    );

    always #4 clk = ~clk;

    task automatic load_trace();
        int                   fd;
        int                   n;
        string                line;
        logic [31:0]          f [12];
        attributed_triangle_t e;
        fd = $fopen("testbench/setup_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file testbench/setup_trace.txt.");
            failures++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (n == 12) begin
                e.triangle.v0.position.x = f[0];
                e.triangle.v0.position.y = f[1];
                e.triangle.v1.position.x = f[2];
                e.triangle.v1.position.y = f[3];
                e.triangle.v2.position.x = f[4];
                e.triangle.v2.position.y = f[5];
                e.area_inv               = f[6];
                e.small_area             = f[7][0];
                e.bounding_box.top       = f[8];
                e.bounding_box.bottom    = f[9];
                e.bounding_box.left      = f[10];
                e.bounding_box.right     = f[11];
                e.meta.id                = tri_count % (1 << `TRI_ID_WIDTH);  // Ids wrap.
                vertex_q.push_back(e.triangle.v0);
                vertex_q.push_back(e.triangle.v1);
                vertex_q.push_back(e.triangle.v2);
                expect_q.push_back(e);
                tri_count++;
            end else if (n > 0) begin
                $display("Malformed trace line with %0d fields: %s", n, line);
                failures++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_field(input string name, input logic [191:0] got,
                               input logic [191:0] want);
        assert (got === want) else begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, want);
            mismatches++;
        end
    endtask

    task automatic check_output(input attributed_triangle_t got);
        attributed_triangle_t want;
        assert (expect_q.size() > 0) else begin
            $display("An output at time %0t arrived after all triangles were received.", $time);
            failures++;
        end
        if (expect_q.size() > 0) begin
            want = expect_q.pop_front();
            check_field("triangle", got.triangle, want.triangle);
            check_field("area_inv", got.area_inv, want.area_inv);
            check_field("small_area", got.small_area, want.small_area);
            check_field("bounding_box", got.bounding_box, want.bounding_box);
            check_field("meta.id", got.meta.id, want.meta.id);
            checked++;
        end
    endtask

    // Vertices go out with random idle gaps.
    task automatic send_vertices();
        vertex_t v;
        int      gap;
        while (vertex_q.size() > 0) begin
            v   = vertex_q.pop_front();
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            vertex_valid = 1'b1;
            vertex       = v;
            while (!vertex_ready) @(negedge clk);
            @(negedge clk);  // Taken on the rising edge just passed.
            vertex_valid = 1'b0;
        end
    endtask

    // Drives out_ready in random stretches and checks every output handshake.
    task automatic serve_output();
        attributed_triangle_t held;
        logic                 hold;
        logic                 level;
        int                   left;
        hold  = 1'b0;
        level = 1'b0;
        left  = 0;
        held  = '0;
        forever begin
            @(negedge clk);
            if (hold) begin
                assert (out_valid) else begin
                    $display("out_valid dropped at time %0t while out_ready was low.", $time);
                    failures++;
                end
                assert (out === held) else begin
                    $display("Mismatch at time %0t: out got %h expected %h", $time, out, held);
                    mismatches++;
                end
            end
            if (left == 0) begin
                level = ($urandom % 4) != 0;
                left  = level ? ($urandom % 60) + 1 : ($urandom % 150) + 1;  // Long stalls.
            end
            left--;
            out_ready = level || draining;
            if (out_valid && out_ready) begin
                check_output(out);
            end
            hold = out_valid && !out_ready;
            held = out;
        end
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = tri_count * 4 * (`FIXED_WIDTH + 8) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d triangles received.",
                 limit, checked, tri_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        vertex_valid = 1'b0;
        vertex       = '0;
        out_ready    = 1'b0;
        tri_count    = 0;
        checked      = 0;
        mismatches   = 0;
        failures     = 0;
        loaded       = 1'b0;
        draining     = 1'b0;
        void'($urandom(SEED));
        load_trace();
        assert (tri_count > 0) else begin
            $display("The trace holds no triangles.");
            failures++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (!out_valid) else begin
            $display("out_valid is high right after reset.");
            failures++;
        end
        assert (vertex_ready) else begin
            $display("vertex_ready is low right after reset.");
            failures++;
        end
        fork
            send_vertices();
            serve_output();
        join_none
        wait (checked == tri_count);
        draining = 1'b1;  // Extra outputs would now show up at once.
        repeat (DRAIN_CYCLES) @(negedge clk);
        assert (!out_valid) else begin
            $display("An extra output is still pending after all triangles were received.");
            failures++;
        end
        $display("Checked %0d of %0d triangles: %0d mismatches, %0d other errors.",
                 checked, tri_count, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/setup_trace.txt */
# x0 y0 x1 y1 x2 y2 area_inv small_area top bottom left right
# Raw hex, signed Q16.16 except small_area, one triangle per line.
00000000 00000000 00040000 00000000 00000000 00040000 00001000 0 00000000 00040000 00000000 00040000
00000000 00000000 00000000 00040000 00040000 00000000 fffff000 1 00000000 00040000 00000000 00040000
00010000 00010000 00020000 00020000 00030000 00030000 7fffffff 1 00010000 00030000 00010000 00030000
00000000 00000000 00000100 00000000 00000000 00000100 7fffffff 1 00000000 00000100 00000000 00000100
00000000 00000000 00010000 00000000 00000000 00010000 00010000 1 00000000 00010000 00000000 00010000
00000000 00000000 00020000 00000000 00000000 00010000 00008000 0 00000000 00010000 00000000 00020000
00000000 00000000 00030000 00000000 00000000 00008000 0000aaaa 1 00000000 00008000 00000000 00030000
00000000 00000000 00030000 00000000 00000000 00010000 00005555 0 00000000 00010000 00000000 00030000
00000000 00000000 00000000 00010000 00030000 00000000 ffffaaab 1 00000000 00010000 00000000 00030000
ff9c0000 ffce0000 00640000 ffce0000 00000000 00320000 00000003 0 ffce0000 00320000 ff9c0000 00640000
ff9c0000 ffce0000 00000000 00320000 00640000 ffce0000 fffffffd 1 ffce0000 00320000 ff9c0000 00640000
00000000 00000000 00c80000 00000000 00000000 00960000 00000002 0 00000000 00960000 00000000 00c80000
00000000 00000000 00000200 00000000 00000000 00000100 7fffffff 1 00000000 00000100 00000000 00000200
00000000 00000000 00000000 00000100 00000200 00000000 80000000 1 00000000 00000100 00000000 00000200
00000000 00000000 00000300 00000000 00000000 00000100 55555555 1 00000000 00000100 00000000 00000300
fff80000 fff80000 fffe0000 fff80000 fff80000 fffc0000 00000aaa 0 fff80000 fffc0000 fff80000 fffe0000
00010000 00010000 00038000 00010000 00010000 00030000 00003333 0 00010000 00030000 00010000 00038000
fffb0000 00070000 fffb0000 00070000 fffb0000 00070000 7fffffff 1 00070000 00070000 fffb0000 fffb0000
000a0000 000a0000 000a0000 00140000 00140000 000a0000 fffffd71 1 000a0000 00140000 000a0000 00140000
000a0000 000a0000 00140000 000a0000 000a0000 00140000 0000028f 0 000a0000 00140000 000a0000 00140000

/* tb.f */
+incdir+logic
logic/raster_pkg.sv
logic/triangle_assembler.sv
logic/stream_fifo.sv
logic/fixed_reciprocal.sv
logic/triangle_setup.sv
logic/raster_setup_top.sv
testbench/tb_raster_setup.sv

/* Bender.yml */
package:
  name: raster_setup

sources:
  - include_dirs:
      - logic
    files:
      - logic/raster_pkg.sv
      - logic/triangle_assembler.sv
      - logic/stream_fifo.sv
      - logic/fixed_reciprocal.sv
      - logic/triangle_setup.sv
      - logic/raster_setup_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_raster_setup.sv
